// File: include/cast_defines.svh
// --------------------
// Integer-to-float cast widths
// Operand, binary32 field widths, bias and tag width
// --------------------
`ifndef CAST_DEFINES_SVH
`define CAST_DEFINES_SVH

// Integer operand, signed or unsigned
`define CAST_INT_WIDTH 32

// binary32 layout
`define CAST_EXP_BITS 8   // Biased exponent field
`define CAST_MAN_BITS 23  // Stored mantissa, hidden bit excluded
`define CAST_BIAS     127

// Pass-through tag
`define CAST_TAG_BITS 8

`endif

// File: rtl/fp_pkg.sv
// --------------------
// Floating-point format types
// RISC-V rounding modes and the binary32 word
// --------------------
`include "cast_defines.svh"

package fp_pkg;

  // --------------------
  // Rounding modes
  // --------------------
  // Encoding follows the RISC-V frm field
  // Codes 5..7 are treated as RNE by the rounder
  typedef enum logic [2:0] {
    RNE = 3'd0,  // Nearest, ties to even
    RTZ = 3'd1,  // Toward zero
    RDN = 3'd2,  // Toward -inf
    RUP = 3'd3,  // Toward +inf
    RMM = 3'd4   // Nearest, ties away from zero
  } roundmode_e;

  // --------------------
  // binary32 word
  // --------------------
  // Field order matches the IEEE 754 bit layout, MSB first
  typedef struct packed {
    logic                      sign;
    logic [`CAST_EXP_BITS-1:0] exponent;  // Biased
    logic [`CAST_MAN_BITS-1:0] mantissa;  // Fraction, hidden bit implied
  } fp32_t;

endpackage

// File: rtl/cast_pipe_pkg.sv
// --------------------
// Pipeline payload structs for the cast unit
// Request, normalized operand and response
// --------------------
`include "cast_defines.svh"

package cast_pipe_pkg;
  import fp_pkg::*;

  typedef logic [`CAST_TAG_BITS-1:0] tag_t;

  // Input stage payload, straight from the ports
  typedef struct packed {
    logic [`CAST_INT_WIDTH-1:0] operand;
    logic                       op_mod;    // 1 = unsigned operand
    roundmode_e                 rnd_mode;
    tag_t                       tag;
  } cast_req_t;

  // Middle stage payload
  // Mantissa is left-aligned, MSB holds the leading one
  typedef struct packed {
    logic                       sign;
    logic                       zero;      // Integer was zero
    logic [`CAST_EXP_BITS-1:0]  exponent;  // Already biased
    logic [`CAST_INT_WIDTH-1:0] mantissa;
    roundmode_e                 rnd_mode;
    tag_t                       tag;
  } norm_t;

  // Output stage payload
  typedef struct packed {
    fp32_t result;
    logic  inexact;  // NX, the only flag an I2F cast to binary32 can raise
    tag_t  tag;
  } cast_rsp_t;

endpackage

// File: rtl/cast_pipe_stage.sv
// --------------------
// Valid/ready register stage with flush
// One payload register, payload type is a parameter
// --------------------
module cast_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;
  logic     load;

  // Take a new item if the slot drains this cycle or is a bubble
  assign ready_o = ready_i | ~valid_q;
  assign load    = valid_i & ready_o;  // Accepted transfer

  // Valid flop, flush wins over any load
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;  // Bubble in when upstream has nothing
    end
  end

  // Payload only moves on an accepted item
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// File: rtl/int_normalizer.sv
// --------------------
// Integer normalizer
// Sign/magnitude split, leading-zero count, left-align
// Produces the biased binary32 exponent
// --------------------
`include "cast_defines.svh"

module int_normalizer
  import cast_pipe_pkg::*;
(
  input  cast_req_t req_i,
  output norm_t     norm_o
);

  localparam int unsigned INT_W = `CAST_INT_WIDTH;
  localparam int unsigned EXP_W = `CAST_EXP_BITS;
  localparam int unsigned LZ_W  = $clog2(INT_W);

  // Exponent of a value whose leading one sits in the operand MSB
  localparam logic [EXP_W-1:0] EXP_TOP = EXP_W'(`CAST_BIAS + INT_W - 1);

  logic             sign;
  logic [INT_W-1:0] magnitude;
  logic [LZ_W-1:0]  lz_cnt;
  logic             mag_zero;

  // --------------------
  // Sign and magnitude
  // --------------------
  assign sign      = req_i.operand[INT_W-1] & ~req_i.op_mod;  // Unsigned is never negative
  assign magnitude = sign ? -req_i.operand : req_i.operand;   // 0x80000000 maps to itself
  assign mag_zero  = (magnitude == '0);

  // --------------------
  // Leading-zero count
  // --------------------
  // Scan upward, the highest set bit is written last and wins
  always_comb begin
    lz_cnt = '0;  // Don't care for a zero magnitude
    for (int i = 0; i < INT_W; i++) begin
      if (magnitude[i]) begin
        lz_cnt = LZ_W'(INT_W - 1 - i);
      end
    end
  end

  // --------------------
  // Output assembly
  // --------------------
  always_comb begin
    norm_o.sign     = sign;
    norm_o.zero     = mag_zero;
    norm_o.mantissa = magnitude << lz_cnt;  // Leading one lands in the MSB
    // Every shift position moves the binary point down by one
    norm_o.exponent = EXP_TOP - EXP_W'(lz_cnt);
    norm_o.rnd_mode = req_i.rnd_mode;       // Pass-through
    norm_o.tag      = req_i.tag;
  end

endmodule

// File: rtl/fp_rounder.sv
// --------------------
// binary32 rounder
// Mantissa/round/sticky split, rounding per RISC-V mode
// Result word and inexact flag
// --------------------
`include "cast_defines.svh"

module fp_rounder
  import fp_pkg::*;
  import cast_pipe_pkg::*;
(
  input  norm_t     norm_i,
  output cast_rsp_t rsp_o
);

  localparam int unsigned INT_W = `CAST_INT_WIDTH;
  localparam int unsigned EXP_W = `CAST_EXP_BITS;
  localparam int unsigned MAN_W = `CAST_MAN_BITS;
  // First bit below the kept mantissa
  localparam int unsigned RND_POS = INT_W - 2 - MAN_W;

  logic [MAN_W-1:0]       man_pre;     // Truncated mantissa
  logic                   round_bit;
  logic                   sticky_bit;
  logic                   round_up;
  logic [EXP_W+MAN_W-1:0] abs_pre;     // {exponent, mantissa} before rounding
  logic [EXP_W+MAN_W-1:0] abs_rnd;
  fp32_t                  result;

  // --------------------
  // Field extraction
  // --------------------
  assign man_pre    = norm_i.mantissa[INT_W-2 -: MAN_W];  // Hidden one dropped
  assign round_bit  = norm_i.mantissa[RND_POS];
  assign sticky_bit = |norm_i.mantissa[RND_POS-1:0];

  // --------------------
  // Rounding decision
  // --------------------
  always_comb begin
    unique case (norm_i.rnd_mode)
      RTZ:     round_up = 1'b0;                                         // Truncate
      RDN:     round_up = norm_i.sign & (round_bit | sticky_bit);       // Grow negatives
      RUP:     round_up = ~norm_i.sign & (round_bit | sticky_bit);      // Grow positives
      RMM:     round_up = round_bit;                                    // Ties away
      default: round_up = round_bit & (sticky_bit | man_pre[0]);        // RNE, ties to even
    endcase
  end

  // Single adder, a mantissa carry rolls into the exponent
  assign abs_pre = {norm_i.exponent, man_pre};
  assign abs_rnd = abs_pre + (EXP_W + MAN_W)'(round_up);

  // --------------------
  // Result assembly
  // --------------------
  always_comb begin
    if (norm_i.zero) begin
      result        = '0;  // Integer zero is +0.0, exact
      rsp_o.inexact = 1'b0;
    end else begin
      result.sign     = norm_i.sign;
      result.exponent = abs_rnd[MAN_W +: EXP_W];
      result.mantissa = abs_rnd[MAN_W-1:0];
      rsp_o.inexact   = round_bit | sticky_bit;  // Any dropped bit
    end
    rsp_o.result = result;
    rsp_o.tag    = norm_i.tag;
  end

endmodule

// File: rtl/int2fp_cast.sv
// --------------------
// Pipelined int32 to binary32 converter, top level
// Input, middle and output register stages
// Normalizer and rounder between them
// --------------------
`include "cast_defines.svh"

module int2fp_cast
  import fp_pkg::*;
  import cast_pipe_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Request
  input  logic [`CAST_INT_WIDTH-1:0] operand_i,
  input  logic                       op_mod_i,     // 1 = unsigned
  input  roundmode_e                 rnd_mode_i,
  input  logic [`CAST_TAG_BITS-1:0]  tag_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic                       flush_i,
  // Response
  output fp32_t                      result_o,
  output logic                       inexact_o,
  output logic [`CAST_TAG_BITS-1:0]  tag_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic                       busy_o       // Anything in flight
);

  cast_req_t req_d, req_q;
  norm_t     norm_d, norm_q;
  cast_rsp_t rsp_d, rsp_q;
  logic      in_valid_q, mid_valid_q, out_valid_q;
  logic      mid_ready, out_ready;  // Ready back from the next stage

  // Gather ports into the request payload
  assign req_d = '{operand: operand_i, op_mod: op_mod_i, rnd_mode: rnd_mode_i, tag: tag_i};

  // --------------------
  // Stage 1, request
  // --------------------
  cast_pipe_stage #(.payload_t(cast_req_t)) u_in_stage (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i (in_valid_i),  .ready_o (in_ready_o), .data_i (req_d),
    .valid_o (in_valid_q),  .ready_i (mid_ready),  .data_o (req_q)
  );

  int_normalizer u_normalizer (.req_i(req_q), .norm_o(norm_d));

  // --------------------
  // Stage 2, normalized
  // --------------------
  cast_pipe_stage #(.payload_t(norm_t)) u_mid_stage (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i (in_valid_q),  .ready_o (mid_ready),  .data_i (norm_d),
    .valid_o (mid_valid_q), .ready_i (out_ready),  .data_o (norm_q)
  );

  fp_rounder u_rounder (.norm_i(norm_q), .rsp_o(rsp_d));

  // --------------------
  // Stage 3, response
  // --------------------
  cast_pipe_stage #(.payload_t(cast_rsp_t)) u_out_stage (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i (mid_valid_q), .ready_o (out_ready),   .data_i (rsp_d),
    .valid_o (out_valid_q), .ready_i (out_ready_i), .data_o (rsp_q)
  );

  // Unpack response onto the ports
  assign result_o    = rsp_q.result;
  assign inexact_o   = rsp_q.inexact;
  assign tag_o       = rsp_q.tag;
  assign out_valid_o = out_valid_q;
  assign busy_o      = in_valid_q | mid_valid_q | out_valid_q;

endmodule

// File: verification/tb_int2fp_cast.sv
// --------------------
// Testbench for the int32 to binary32 converter
// Directed tasks for exact casts, rounding modes, ties,
// back-pressure and flush, with typed compare tasks
// --------------------
`include "cast_defines.svh"

module tb_int2fp_cast
  import fp_pkg::*;
  import cast_pipe_pkg::*;
;

  localparam int TIMEOUT = 20;  // Cycles allowed for any single wait
  localparam int LATENCY = 2;   // Edges after the accepting one, three registers in all

  logic                       clk;
  logic                       rst_n;
  logic [`CAST_INT_WIDTH-1:0] operand;
  logic                       op_mod;
  roundmode_e                 rnd_mode;
  tag_t                       tag_in;
  logic                       in_valid;
  logic                       in_ready;
  logic                       flush;
  fp32_t                      result;
  logic                       inexact;
  tag_t                       tag_out;
  logic                       out_valid;
  logic                       out_ready;
  logic                       busy;
  tag_t                       next_tag;

  int2fp_cast int2fp_cast_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .operand_i (operand), .op_mod_i (op_mod), .rnd_mode_i (rnd_mode), .tag_i (tag_in),
    .in_valid_i (in_valid), .in_ready_o (in_ready), .flush_i (flush),
    .result_o (result), .inexact_o (inexact), .tag_o (tag_out),
    .out_valid_o (out_valid), .out_ready_i (out_ready), .busy_o (busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // Period 100
  end

  // --------------------
  // Failure and compare tasks
  // --------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic compare_word(input string name, input fp32_t got, input fp32_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic expect_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic verify_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp)
      stop_on_error($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // --------------------
  // Handshake tasks
  // --------------------
  // All of them start and end on a falling edge, sampling 1 unit later
  task automatic send_request(input logic [`CAST_INT_WIDTH-1:0] op, input logic is_unsigned,
                              input roundmode_e mode, input tag_t t);
    int cycles;
    cycles   = 0;
    operand  = op;
    op_mod   = is_unsigned;
    rnd_mode = mode;
    tag_in   = t;
    in_valid = 1'b1;
    #1;
    while (!in_ready) begin  // Stalled by a full pipeline
      cycles++;
      if (cycles > TIMEOUT) stop_on_error("Request was not accepted before the timeout");
      @(negedge clk);
      #1;
    end
    @(negedge clk);          // Accepting edge has passed
    in_valid = 1'b0;
  endtask

  task automatic take_response(input fp32_t exp_word, input logic exp_nx, input tag_t exp_tag,
                               output int waited);
    waited = 0;
    #1;
    while (!out_valid) begin
      waited++;
      if (waited > TIMEOUT) stop_on_error("No response arrived before the timeout");
      @(negedge clk);
      #1;
    end
    compare_word("result_o", result, exp_word);
    expect_flag("inexact_o", inexact, exp_nx);
    verify_tag("tag_o", tag_out, exp_tag);
    @(negedge clk);  // Handshake completes on the rising edge before this
  endtask

  // One request in an empty pipeline, latency checked too
  task automatic convert_one(input logic [`CAST_INT_WIDTH-1:0] op, input logic is_unsigned,
                             input roundmode_e mode, input logic [31:0] exp_word,
                             input logic exp_nx);
    int waited;
    send_request(op, is_unsigned, mode, next_tag);
    take_response(fp32_t'(exp_word), exp_nx, next_tag, waited);
    if (waited != LATENCY)
      stop_on_error($sformatf("Response came %0d cycles after acceptance instead of %0d",
                              waited, LATENCY));
    next_tag = next_tag + 8'd1;
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic reset_values();
    #1;
    expect_flag("out_valid_o", out_valid, 1'b0);
    expect_flag("busy_o", busy, 1'b0);
    expect_flag("in_ready_o", in_ready, 1'b1);
    @(negedge clk);
  endtask

  task automatic exact_conversions();
    convert_one(32'h0000_0000, 1'b0, RNE, 32'h0000_0000, 1'b0);  // Zero, both kinds
    convert_one(32'h0000_0000, 1'b1, RDN, 32'h0000_0000, 1'b0);
    convert_one(32'h0000_0001, 1'b0, RNE, 32'h3f80_0000, 1'b0);  // 1.0
    convert_one(32'hffff_ffff, 1'b0, RNE, 32'hbf80_0000, 1'b0);  // -1.0
    convert_one(32'h8000_0000, 1'b0, RNE, 32'hcf00_0000, 1'b0);  // -2^31
    convert_one(32'h8000_0000, 1'b1, RNE, 32'h4f00_0000, 1'b0);  // +2^31
  endtask

  task automatic rounding_modes();
    // 2^31-1 sits between 0x4effffff and 0x4f000000
    convert_one(32'h7fff_ffff, 1'b0, RNE, 32'h4f00_0000, 1'b1);
    convert_one(32'h7fff_ffff, 1'b0, RUP, 32'h4f00_0000, 1'b1);
    convert_one(32'h7fff_ffff, 1'b0, RMM, 32'h4f00_0000, 1'b1);
    convert_one(32'h7fff_ffff, 1'b0, RTZ, 32'h4eff_ffff, 1'b1);
    convert_one(32'h7fff_ffff, 1'b0, RDN, 32'h4eff_ffff, 1'b1);
    // Negative side, directed modes swap
    convert_one(32'h8000_0001, 1'b0, RDN, 32'hcf00_0000, 1'b1);
    convert_one(32'h8000_0001, 1'b0, RUP, 32'hceff_ffff, 1'b1);
    convert_one(32'h8000_0001, 1'b0, RTZ, 32'hceff_ffff, 1'b1);
  endtask

  task automatic tie_cases();
    convert_one(32'h0100_0001, 1'b0, RNE, 32'h4b80_0000, 1'b1);  // Even LSB kept
    convert_one(32'h0100_0001, 1'b0, RMM, 32'h4b80_0001, 1'b1);  // Away from zero
    convert_one(32'hffff_ffff, 1'b1, RNE, 32'h4f80_0000, 1'b1);  // Carry into exponent
  endtask

  task automatic back_pressure();
    int waited;
    out_ready = 1'b0;
    send_request(32'h0000_0001, 1'b0, RNE, 8'h10);
    send_request(32'hffff_ffff, 1'b0, RNE, 8'h11);
    send_request(32'h7fff_ffff, 1'b0, RNE, 8'h12);
    // Fourth offer, all stages full now
    operand  = 32'h0100_0001;
    rnd_mode = RMM;
    tag_in   = 8'h13;
    in_valid = 1'b1;
    repeat (3) begin
      #1;
      expect_flag("in_ready_o", in_ready, 1'b0);
      expect_flag("busy_o", busy, 1'b1);
      expect_flag("out_valid_o", out_valid, 1'b1);
      verify_tag("tag_o", tag_out, 8'h10);              // Output holds the oldest
      compare_word("result_o", result, 32'h3f80_0000);
      @(negedge clk);
    end
    in_valid  = 1'b0;  // Withdrawn, never accepted
    out_ready = 1'b1;
    take_response(32'h3f80_0000, 1'b0, 8'h10, waited);  // Drains in order
    take_response(32'hbf80_0000, 1'b0, 8'h11, waited);
    take_response(32'h4f00_0000, 1'b1, 8'h12, waited);
    send_request(32'h0100_0001, 1'b0, RMM, 8'h13);
    take_response(32'h4b80_0001, 1'b1, 8'h13, waited);
  endtask

  task automatic flush_pipeline();
    out_ready = 1'b0;
    send_request(32'h0000_0001, 1'b0, RNE, 8'h20);
    send_request(32'h0000_0002, 1'b0, RNE, 8'h21);  // Two stages hold items
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    repeat (3) begin  // Nothing may come out
      #1;
      expect_flag("out_valid_o", out_valid, 1'b0);
      expect_flag("busy_o", busy, 1'b0);
      @(negedge clk);
    end
    out_ready = 1'b1;
    convert_one(32'h0000_0003, 1'b0, RNE, 32'h4040_0000, 1'b0);  // 3.0 after flush
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rst_n     = 1'b0;
    operand   = '0;
    op_mod    = 1'b0;
    rnd_mode  = RNE;
    tag_in    = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b1;
    next_tag  = 8'h01;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;  // Released on a falling edge
    reset_values();
    exact_conversions();
    rounding_modes();
    tie_cases();
    back_pressure();
    flush_pipeline();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
rtl/fp_pkg.sv
rtl/cast_pipe_pkg.sv
rtl/cast_pipe_stage.sv
rtl/int_normalizer.sv
rtl/fp_rounder.sv
rtl/int2fp_cast.sv
verification/tb_int2fp_cast.sv

// File: Makefile
TOP := tb_int2fp_cast

.PHONY: sim clean

# Build and run; $fatal in the testbench gives a non-zero exit status
sim:
	verilator --binary -j 0 --top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
